// ==== tb.f ====
md_op_pkg.sv
md_state_pkg.sv
md_ctrl.sv
md_adder.sv
md_datapath.sv
md_top.sv
tb_md.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_md
VFLAGS    ?= --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir

// ==== tb_md.sv ====
`timescale 1ns/10ps

module tb_md;

	localparam int DataWidth   = 32;
	localparam int NumRand     = 8;               // Random operations per mode
	localparam int NumOps      = 12 * NumRand + 6;
	localparam int TimeoutCyc  = NumOps * 50 + 100;
	localparam int MulLatency  = 33;
	localparam int DivLatency  = 37;

	logic                 clk_i;
	logic                 rst_ni;
	logic                 en_i;
	md_op_pkg::md_op_e    operator_i;
	logic [1:0]           signed_mode_i;
	logic [DataWidth-1:0] op_a_i;
	logic [DataWidth-1:0] op_b_i;
	logic                 ready_i;
	logic [DataWidth-1:0] result_o;
	logic                 valid_o;

	int          errors;
	int          test_start_errors;
	int          pass_count;
	int          fail_count;
	int unsigned cycle_count;

	md_top #(
		.DataWidth(DataWidth)
	) uut (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.en_i         (en_i),
		.operator_i   (operator_i),
		.signed_mode_i(signed_mode_i),
		.op_a_i       (op_a_i),
		.op_b_i       (op_b_i),
		.ready_i      (ready_i),
		.result_o     (result_o),
		.valid_o      (valid_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Reference results from 64-bit arithmetic on extended operands
	function automatic logic [31:0] model_result(input md_op_pkg::md_op_e op,
		input logic [1:0] mode, input logic [31:0] a, input logic [31:0] b);
		logic [63:0] a_ext;
		logic [63:0] b_ext;
		logic [63:0] prod;
		logic [63:0] quot;
		logic [63:0] rem;
		longint      sa;
		longint      sb;
		a_ext = mode[md_op_pkg::SIGNED_A_BIT] ? {{32{a[31]}}, a} : {32'b0, a};
		b_ext = mode[md_op_pkg::SIGNED_B_BIT] ? {{32{b[31]}}, b} : {32'b0, b};
		prod  = a_ext * b_ext;
		sa    = a_ext;
		sb    = b_ext;
		if (b == 32'b0) begin
			quot = 64'hffff_ffff_ffff_ffff;
			rem  = a_ext;
		end else begin
			quot = sa / sb; // Truncating signed division
			rem  = sa % sb;
		end
		case (op)
			md_op_pkg::MD_OP_MULL: return prod[31:0];
			md_op_pkg::MD_OP_MULH: return prod[63:32];
			md_op_pkg::MD_OP_DIV:  return quot[31:0];
			default:               return rem[31:0];
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch %s: expected %h, got %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("Error: %s", msg);
		errors++;
	endtask

	task automatic run_op(input md_op_pkg::md_op_e op, input logic [1:0] mode,
		input logic [31:0] a, input logic [31:0] b);
		int          cycles;
		int          hold;
		int          latency;
		logic [31:0] expected;
		logic [31:0] held;
		expected = model_result(op, mode, a, b);
		latency  = (op == md_op_pkg::MD_OP_MULL || op == md_op_pkg::MD_OP_MULH) ?
			MulLatency : DivLatency;
		hold     = int'($urandom % 8); // Cycles with ready_i low once valid_o is up
		@(posedge clk_i);
		en_i          <= 1'b1;
		operator_i    <= op;
		signed_mode_i <= mode;
		op_a_i        <= a;
		op_b_i        <= b;
		ready_i       <= (hold == 0);
		cycles = 0;
		do begin
			@(negedge clk_i);
			cycles++;
		end while (!valid_o && cycles < latency + 8);
		assert (valid_o) else report_error($sformatf("valid_o never rose for %s", op.name()));
		assert (cycles == latency) else report_error($sformatf(
			"%s finished in cycle %0d instead of cycle %0d", op.name(), cycles, latency));
		compare("result_o", expected, result_o);
		held = result_o;
		for (int i = 0; i < hold; i++) begin
			@(posedge clk_i);
			if (i == hold - 1) ready_i <= 1'b1;
			@(negedge clk_i);
			compare("valid_o", 32'd1, {31'b0, valid_o});
			compare("result_o", held, result_o);
		end
		@(posedge clk_i);
		en_i    <= 1'b0;
		ready_i <= 1'b0;
		@(negedge clk_i);
		compare("valid_o", 32'd0, {31'b0, valid_o}); // Back in idle after acceptance
	endtask

	task automatic start_test();
		test_start_errors = errors;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_start_errors) begin
			$display("PASS %s", name);
			pass_count++;
		end else begin
			$display("FAIL %s with %0d errors", name, errors - test_start_errors);
			fail_count++;
		end
	endtask

	initial begin
		void'($urandom(32'ha34a8dae));
		errors        = 0;
		pass_count    = 0;
		fail_count    = 0;
		rst_ni        = 1'b0;
		en_i          = 1'b0;
		ready_i       = 1'b0;
		operator_i    = md_op_pkg::MD_OP_MULL;
		signed_mode_i = 2'b00;
		op_a_i        = '0;
		op_b_i        = '0;

		start_test();
		repeat (2) @(posedge clk_i);
		rst_ni <= 1'b1;
		repeat (3) begin
			@(negedge clk_i);
			compare("valid_o", 32'd0, {31'b0, valid_o});
		end
		finish_test("reset");

		start_test();
		for (int m = 0; m < 4; m++) begin
			for (int k = 0; k < NumRand; k++) run_op(md_op_pkg::MD_OP_MULL, 2'(m), $urandom, $urandom);
		end
		finish_test("MULL all signed modes");

		start_test();
		for (int m = 0; m < 4; m++) begin
			for (int k = 0; k < NumRand; k++) run_op(md_op_pkg::MD_OP_MULH, 2'(m), $urandom, $urandom);
		end
		finish_test("MULH, MULHSU and MULHU");

		start_test();
		for (int m = 0; m < 4; m += 3) begin
			for (int k = 0; k < NumRand; k++) begin
				run_op(md_op_pkg::MD_OP_DIV, 2'(m), $urandom, $urandom >> ($urandom % 32));
				run_op(md_op_pkg::MD_OP_REM, 2'(m), $urandom, $urandom >> ($urandom % 32));
			end
		end
		// Divide by zero and signed overflow
		run_op(md_op_pkg::MD_OP_DIV, 2'b00, 32'h1234_5678, 32'h0);
		run_op(md_op_pkg::MD_OP_REM, 2'b00, 32'h8765_4321, 32'h0);
		run_op(md_op_pkg::MD_OP_DIV, 2'b11, 32'hffff_fff3, 32'h0);
		run_op(md_op_pkg::MD_OP_REM, 2'b11, 32'hffff_fff3, 32'h0);
		run_op(md_op_pkg::MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hffff_ffff);
		run_op(md_op_pkg::MD_OP_REM, 2'b11, 32'h8000_0000, 32'hffff_ffff);
		finish_test("DIV and REM with corners");

		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog sized from the number of operations
	initial begin
		cycle_count = 0;
		while (cycle_count < TimeoutCyc) begin
			@(posedge clk_i);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TimeoutCyc);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== md_top.sv ====
`timescale 1ns/10ps

module md_top #(
	// Only the default width is supported by the accumulator union
	parameter int unsigned DataWidth = md_op_pkg::DATA_WIDTH_DEFAULT
) (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 en_i,
	input  md_op_pkg::md_op_e    operator_i,
	input  logic [1:0]           signed_mode_i,
	input  logic [DataWidth-1:0] op_a_i,
	input  logic [DataWidth-1:0] op_b_i,
	input  logic                 ready_i,
	output logic [DataWidth-1:0] result_o,
	output logic                 valid_o
);

	md_state_pkg::md_state_e      state;
	logic [$clog2(DataWidth)-1:0] count;
	logic                         step;
	md_state_pkg::md_accum_u      accum;
	logic [DataWidth:0]           op_a_shift;
	logic [DataWidth:0]           op_b_shift;
	logic [DataWidth:0]           pp;
	logic [DataWidth:0]           pp_last;
	logic [DataWidth+1:0]         sum;

	md_ctrl #(
		.DataWidth(DataWidth)
	) u_ctrl (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.en_i      (en_i),
		.operator_i(operator_i),
		.ready_i   (ready_i),
		.state_o   (state),
		.count_o   (count),
		.step_o    (step),
		.valid_o   (valid_o)
	);

	md_adder #(
		.DataWidth(DataWidth)
	) u_adder (
		.state_i     (state),
		.operator_i  (operator_i),
		.op_a_i      (op_a_i),
		.op_b_i      (op_b_i),
		.accum_i     (accum),
		.op_a_shift_i(op_a_shift),
		.op_b_shift_i(op_b_shift),
		.pp_i        (pp),
		.pp_last_i   (pp_last),
		.sum_o       (sum)
	);

	md_datapath #(
		.DataWidth(DataWidth)
	) u_datapath (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.step_i       (step),
		.state_i      (state),
		.count_i      (count),
		.operator_i   (operator_i),
		.signed_mode_i(signed_mode_i),
		.op_a_i       (op_a_i),
		.op_b_i       (op_b_i),
		.sum_i        (sum),
		.accum_o      (accum),
		.op_a_shift_o (op_a_shift),
		.op_b_shift_o (op_b_shift),
		.pp_o         (pp),
		.pp_last_o    (pp_last),
		.result_o     (result_o)
	);

endmodule

// ==== md_datapath.sv ====
`timescale 1ns/10ps

module md_datapath #(
	parameter int unsigned DataWidth = md_op_pkg::DATA_WIDTH_DEFAULT
) (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         step_i,
	input  md_state_pkg::md_state_e      state_i,
	input  logic [$clog2(DataWidth)-1:0] count_i,
	input  md_op_pkg::md_op_e            operator_i,
	input  logic [1:0]                   signed_mode_i,
	input  logic [DataWidth-1:0]         op_a_i,
	input  logic [DataWidth-1:0]         op_b_i,
	input  logic [DataWidth+1:0]         sum_i,
	output md_state_pkg::md_accum_u      accum_o,
	output logic [DataWidth:0]           op_a_shift_o,
	output logic [DataWidth:0]           op_b_shift_o,
	output logic [DataWidth:0]           pp_o,
	output logic [DataWidth:0]           pp_last_o,
	output logic [DataWidth-1:0]         result_o
);

	md_state_pkg::md_accum_u      accum_q;
	md_state_pkg::md_accum_u      accum_d;
	logic [DataWidth:0]           op_a_shift_q;
	logic [DataWidth:0]           op_a_shift_d;
	logic [DataWidth:0]           op_b_shift_q;
	logic [DataWidth:0]           op_b_shift_d;
	logic [DataWidth-1:0]         numerator_q;
	logic [DataWidth-1:0]         numerator_d;
	logic                         div_by_zero_q;
	logic                         div_by_zero_d;
	logic                         sign_a;
	logic                         sign_b;
	logic [DataWidth:0]           op_a_ext;
	logic [DataWidth:0]           op_b_ext;
	logic [DataWidth:0]           sum_h;
	logic [DataWidth-1:0]         rem_window;
	logic [DataWidth-1:0]         b_0;
	logic                         is_greater_equal;
	logic [DataWidth-1:0]         next_remainder;
	logic [DataWidth:0]           one_shift;
	logic [DataWidth:0]           next_quotient;
	logic [$clog2(DataWidth)-1:0] count_next;
	logic                         div_change_sign;
	logic                         rem_change_sign;
	logic                         is_mult;

	assign sign_a   = op_a_i[DataWidth-1] & signed_mode_i[md_op_pkg::SIGNED_A_BIT];
	assign sign_b   = op_b_i[DataWidth-1] & signed_mode_i[md_op_pkg::SIGNED_B_BIT];
	assign op_a_ext = {sign_a, op_a_i};
	assign op_b_ext = {sign_b, op_b_i};
	assign sum_h    = sum_i[DataWidth+1:1]; // Also holds the negations and differences
	assign is_mult  = (operator_i == md_op_pkg::MD_OP_MULL) |
		(operator_i == md_op_pkg::MD_OP_MULH);

	// Baugh-Wooley partial products with inverted sign terms
	assign b_0       = {DataWidth{op_b_shift_q[0]}};
	assign pp_o      = {~(op_a_shift_q[DataWidth] & op_b_shift_q[0]),
		op_a_shift_q[DataWidth-1:0] & b_0};
	assign pp_last_o = {op_a_shift_q[DataWidth] & op_b_shift_q[0],
		~(op_a_shift_q[DataWidth-1:0] & b_0)};

	// Remainder shifted left with the next numerator bit
	assign rem_window = {accum_q.div.rem[DataWidth-2:0], accum_q.div.nbit};

	// Unsigned compare from the top bits and the sign of the difference
	assign is_greater_equal = (rem_window[DataWidth-1] == op_b_shift_q[DataWidth-1]) ?
		~sum_h[DataWidth-1] : rem_window[DataWidth-1];

	assign one_shift       = {{DataWidth{1'b0}}, 1'b1} << count_i;
	assign next_remainder  = is_greater_equal ? sum_h[DataWidth-1:0] : rem_window;
	assign next_quotient   = is_greater_equal ? (op_a_shift_q | one_shift) : op_a_shift_q;
	assign count_next      = count_i - 1'b1;
	assign div_change_sign = (sign_a ^ sign_b) & ~div_by_zero_q;
	assign rem_change_sign = sign_a;

	always_comb begin
		accum_d       = accum_q;
		op_a_shift_d  = op_a_shift_q;
		op_b_shift_d  = op_b_shift_q;
		numerator_d   = numerator_q;
		div_by_zero_d = div_by_zero_q;
		case (state_i)
			md_state_pkg::MD_IDLE: begin
				div_by_zero_d = (op_b_i == '0);
				if (operator_i == md_op_pkg::MD_OP_MULL) begin
					op_a_shift_d = op_a_ext << 1;
					accum_d      = {~(op_a_ext[DataWidth] & op_b_i[0]),
						op_a_ext[DataWidth-1:0] & {DataWidth{op_b_i[0]}}};
					op_b_shift_d = op_b_ext >> 1;
				end else if (operator_i == md_op_pkg::MD_OP_MULH) begin
					op_a_shift_d = op_a_ext;
					accum_d      = {1'b1, ~(op_a_ext[DataWidth] & op_b_i[0]),
						op_a_ext[DataWidth-1:1] & {(DataWidth-1){op_b_i[0]}}};
					op_b_shift_d = op_b_ext >> 1;
				end
			end
			md_state_pkg::MD_ABS_A: begin
				op_a_shift_d = '0; // Quotient builds up here
				numerator_d  = sign_a ? sum_h[DataWidth-1:0] : op_a_i;
			end
			md_state_pkg::MD_ABS_B: begin
				accum_d.div.rem  = '0;
				accum_d.div.nbit = numerator_q[DataWidth-1];
				op_b_shift_d     = {1'b0, sign_b ? sum_h[DataWidth-1:0] : op_b_i};
			end
			md_state_pkg::MD_COMP: begin
				case (operator_i)
					md_op_pkg::MD_OP_MULL: begin
						accum_d      = sum_i[DataWidth:0];
						op_a_shift_d = op_a_shift_q << 1;
						op_b_shift_d = op_b_shift_q >> 1;
					end
					md_op_pkg::MD_OP_MULH: begin
						accum_d      = sum_h; // Product slides down one bit per step
						op_b_shift_d = op_b_shift_q >> 1;
					end
					default: begin
						accum_d.div.rem  = next_remainder;
						accum_d.div.nbit = numerator_q[count_next];
						op_a_shift_d     = next_quotient;
					end
				endcase
			end
			md_state_pkg::MD_LAST: begin
				if (operator_i == md_op_pkg::MD_OP_DIV) begin
					op_a_shift_d = next_quotient;
				end else if (operator_i == md_op_pkg::MD_OP_REM) begin
					accum_d = {1'b0, next_remainder};
				end
			end
			md_state_pkg::MD_CHANGE_SIGN: begin
				if (operator_i == md_op_pkg::MD_OP_DIV) begin
					accum_d = {1'b0, div_change_sign ? sum_h[DataWidth-1:0] :
						op_a_shift_q[DataWidth-1:0]};
				end else begin
					accum_d = {1'b0, rem_change_sign ? sum_h[DataWidth-1:0] : accum_q.mul.sum};
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			accum_q       <= '0;
			op_a_shift_q  <= '0;
			op_b_shift_q  <= '0;
			numerator_q   <= '0;
			div_by_zero_q <= 1'b0;
		end else if (step_i) begin
			accum_q       <= accum_d;
			op_a_shift_q  <= op_a_shift_d;
			op_b_shift_q  <= op_b_shift_d;
			numerator_q   <= numerator_d;
			div_by_zero_q <= div_by_zero_d;
		end
	end

	assign accum_o      = accum_q;
	assign op_a_shift_o = op_a_shift_q;
	assign op_b_shift_o = op_b_shift_q;

	// Multiply result comes from the final addition in LAST
	assign result_o = is_mult ? sum_i[DataWidth-1:0] : accum_q.mul.sum;

endmodule

// ==== md_adder.sv ====
`timescale 1ns/10ps

module md_adder #(
	parameter int unsigned DataWidth = md_op_pkg::DATA_WIDTH_DEFAULT
) (
	input  md_state_pkg::md_state_e state_i,
	input  md_op_pkg::md_op_e       operator_i,
	input  logic [DataWidth-1:0]    op_a_i,
	input  logic [DataWidth-1:0]    op_b_i,
	input  md_state_pkg::md_accum_u accum_i,
	input  logic [DataWidth:0]      op_a_shift_i,
	input  logic [DataWidth:0]      op_b_shift_i,
	input  logic [DataWidth:0]      pp_i,
	input  logic [DataWidth:0]      pp_last_i,
	output logic [DataWidth+1:0]    sum_o
);

	logic [DataWidth:0] opa;
	logic [DataWidth:0] opb;

	// Divide operands carry a forced one in bit 0 so that {~x, 1} + {y, 1} gives y - x above it
	always_comb begin
		opa = accum_i;
		opb = pp_i;
		case (operator_i)
			md_op_pkg::MD_OP_MULL: opb = pp_i;
			md_op_pkg::MD_OP_MULH: begin
				opb = (state_i == md_state_pkg::MD_LAST) ? pp_last_i : pp_i;
			end
			default: begin
				case (state_i)
					md_state_pkg::MD_ABS_A: begin
						opa = {{DataWidth{1'b0}}, 1'b1};
						opb = {~op_a_i, 1'b1};
					end
					md_state_pkg::MD_ABS_B: begin
						opa = {{DataWidth{1'b0}}, 1'b1};
						opb = {~op_b_i, 1'b1};
					end
					md_state_pkg::MD_CHANGE_SIGN: begin
						opa = {{DataWidth{1'b0}}, 1'b1};
						// Quotient is negated straight from its shift register
						if (operator_i == md_op_pkg::MD_OP_DIV) begin
							opb = {~op_a_shift_i[DataWidth-1:0], 1'b1};
						end else begin
							opb = {~accum_i.mul.sum, 1'b1};
						end
					end
					default: begin
						// Shifted remainder minus divisor
						opa = {accum_i.div.rem[DataWidth-2:0], accum_i.div.nbit, 1'b1};
						opb = {~op_b_shift_i[DataWidth-1:0], 1'b1};
					end
				endcase
			end
		endcase
	end

	assign sum_o = {1'b0, opa} + {1'b0, opb};

endmodule

// ==== md_ctrl.sv ====
`timescale 1ns/10ps

module md_ctrl #(
	parameter int unsigned DataWidth = md_op_pkg::DATA_WIDTH_DEFAULT
) (
	input  logic                         clk_i,
	input  logic                         rst_ni,
	input  logic                         en_i,
	input  md_op_pkg::md_op_e            operator_i,
	input  logic                         ready_i,
	output md_state_pkg::md_state_e      state_o,
	output logic [$clog2(DataWidth)-1:0] count_o,
	output logic                         step_o,
	output logic                         valid_o
);

	localparam int unsigned CountWidth = $clog2(DataWidth);

	md_state_pkg::md_state_e state_q;
	md_state_pkg::md_state_e state_d;
	logic [CountWidth-1:0]   count_q;
	logic [CountWidth-1:0]   count_d;
	logic                    is_mult;
	logic                    hold;

	assign is_mult = (operator_i == md_op_pkg::MD_OP_MULL) |
		(operator_i == md_op_pkg::MD_OP_MULH);

	always_comb begin
		state_d = state_q;
		count_d = count_q;
		case (state_q)
			md_state_pkg::MD_IDLE: begin
				count_d = CountWidth'(DataWidth - 1);
				state_d = is_mult ? md_state_pkg::MD_COMP : md_state_pkg::MD_ABS_A;
			end
			md_state_pkg::MD_ABS_A: state_d = md_state_pkg::MD_ABS_B;
			md_state_pkg::MD_ABS_B: state_d = md_state_pkg::MD_COMP;
			md_state_pkg::MD_COMP: begin
				count_d = count_q - CountWidth'(1);
				if (count_q == CountWidth'(1)) begin
					state_d = md_state_pkg::MD_LAST; // Bit 0 is handled in LAST
				end
			end
			md_state_pkg::MD_LAST: begin
				state_d = is_mult ? md_state_pkg::MD_IDLE : md_state_pkg::MD_CHANGE_SIGN;
			end
			md_state_pkg::MD_CHANGE_SIGN: state_d = md_state_pkg::MD_FINISH;
			md_state_pkg::MD_FINISH: state_d = md_state_pkg::MD_IDLE;
			default: state_d = md_state_pkg::MD_IDLE;
		endcase
	end

	// Multiplies present their result in LAST straight from the adder
	assign valid_o = (state_q == md_state_pkg::MD_FINISH) |
		((state_q == md_state_pkg::MD_LAST) & is_mult);

	assign hold   = valid_o & ~ready_i; // Keep the result until it is taken
	assign step_o = en_i & ~hold;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= md_state_pkg::MD_IDLE;
			count_q <= '0;
		end else if (step_o) begin
			state_q <= state_d;
			count_q <= count_d;
		end
	end

	assign state_o = state_q;
	assign count_o = count_q;

endmodule

// ==== md_state_pkg.sv ====
package md_state_pkg;

	// Iteration states of the multiply/divide FSM
	typedef enum logic [2:0] {
		MD_IDLE        = 3'd0,
		MD_ABS_A       = 3'd1, // Divide only
		MD_ABS_B       = 3'd2, // Divide only
		MD_COMP        = 3'd3,
		MD_LAST        = 3'd4,
		MD_CHANGE_SIGN = 3'd5, // Divide only
		MD_FINISH      = 3'd6
	} md_state_e;

	// Accumulator window
	// Multiply keeps a carry/sign bit over the partial sum
	// Divide keeps the partial remainder over the next numerator bit
	typedef union packed {
		struct packed {
			logic        carry;
			logic [31:0] sum;
		} mul;
		struct packed {
			logic [31:0] rem;
			logic        nbit;
		} div;
	} md_accum_u;

endpackage

// ==== md_op_pkg.sv ====
package md_op_pkg;

	// Operation selected for the multiply/divide unit
	typedef enum logic [1:0] {
		MD_OP_MULL = 2'd0, // Low word of the product
		MD_OP_MULH = 2'd1, // High word of the product
		MD_OP_DIV  = 2'd2,
		MD_OP_REM  = 2'd3
	} md_op_e;

	// Signed mode field
	// Each bit marks one operand as a two's-complement value
	localparam int unsigned SIGNED_A_BIT = 0;
	localparam int unsigned SIGNED_B_BIT = 1;

	// Operand and result width
	localparam int unsigned DATA_WIDTH_DEFAULT = 32;

endpackage
